/* Makefile */
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/compressed_expander.sv */
// --------------------
// Expands supported RVC instructions to their 32-bit form.
// Full-width words pass through, anything else is flagged illegal.
// --------------------
`timescale 1ns/1ps

module compressed_expander
  import decode_pkg::*;
(
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  // Full register fields
  logic [4:0]  rd_full;
  logic [4:0]  rs2_full;
  // Popular-register fields map to x8..x15
  logic [4:0]  rd_p;
  logic [4:0]  rs1_p;
  // Sign-extended 6-bit immediate of CI format
  logic [11:0] imm_ci;

  assign rd_full  = instr_i[11:7];
  assign rs2_full = instr_i[6:2];
  assign rd_p     = {2'b01, instr_i[4:2]};
  assign rs1_p    = {2'b01, instr_i[9:7]};
  assign imm_ci   = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};

  always_comb begin
    // 32-bit words go through untouched
    instr_o         = instr_i;
    is_compressed_o = 1'b0;
    illegal_o       = 1'b0;

    if (instr_i[1:0] != 2'b11) begin
      // Unsupported until a case below claims it
      is_compressed_o = 1'b1;
      instr_o         = '0;
      illegal_o       = 1'b1;

      // Select on quadrant and funct3
      case ({instr_i[1:0], instr_i[15:13]})
        // C.LW -> lw rd', uimm(rs1')
        5'b00_010: begin
          instr_o   = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                       rs1_p, 3'b010, rd_p, OPCODE_LOAD};
          illegal_o = 1'b0;
        end
        // C.SW -> sw rs2', uimm(rs1')
        5'b00_110: begin
          instr_o   = {5'b0, instr_i[5], instr_i[12], rd_p, rs1_p, 3'b010,
                       instr_i[11:10], instr_i[6], 2'b00, OPCODE_STORE};
          illegal_o = 1'b0;
        end
        // C.ADDI -> addi rd, rd, imm
        5'b01_000: begin
          instr_o   = {imm_ci, rd_full, 3'b000, rd_full, OPCODE_OP_IMM};
          illegal_o = 1'b0;
        end
        // C.LI -> addi rd, x0, imm
        5'b01_010: begin
          instr_o   = {imm_ci, 5'b0, 3'b000, rd_full, OPCODE_OP_IMM};
          illegal_o = 1'b0;
        end
        // C.LUI, rd of x0 or x2 and a zero immediate are reserved here
        5'b01_011: begin
          if (rd_full != 5'd0 && rd_full != 5'd2 && {instr_i[12], instr_i[6:2]} != 6'd0) begin
            instr_o   = {{14{instr_i[12]}}, instr_i[12], instr_i[6:2], rd_full, OPCODE_LUI};
            illegal_o = 1'b0;
          end
        end
        // C.J -> jal x0, offset
        5'b01_101: begin
          instr_o   = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                       instr_i[2], instr_i[11], instr_i[5:3], instr_i[12],
                       {8{instr_i[12]}}, 5'b0, OPCODE_JAL};
          illegal_o = 1'b0;
        end
        // C.BEQZ and C.BNEZ, funct3 bit 0 picks bne
        5'b01_110, 5'b01_111: begin
          instr_o   = {instr_i[12], {3{instr_i[12]}}, instr_i[6:5], instr_i[2], 5'b0,
                       rs1_p, {2'b00, instr_i[13]}, instr_i[11:10], instr_i[4:3],
                       instr_i[12], OPCODE_BRANCH};
          illegal_o = 1'b0;
        end
        // C.MV and C.ADD, zero rs2 is jr/jalr/ebreak and not supported
        5'b10_100: begin
          if (rs2_full != 5'd0) begin
            instr_o   = {7'b0, rs2_full, (instr_i[12] ? rd_full : 5'd0), 3'b000,
                         rd_full, OPCODE_OP};
            illegal_o = 1'b0;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* hdl/decode_pkg.sv */
// --------------------
// Shared decode types and constants for the decode stage.
// Imported by the expander, the decoder and the stage modules.
// --------------------
package decode_pkg;

  // --------------------
  // RV32I major opcodes
  // --------------------
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;

  // Exception cause for an illegal instruction
  localparam logic [31:0] ILLEGAL_CAUSE = 32'd2;

  // Functional unit that executes the entry
  typedef enum logic [2:0] {
    FU_NONE,
    FU_ALU,
    FU_BRANCH,
    FU_LOAD,
    FU_STORE
  } fu_t;

  // Operation within the functional unit
  typedef enum logic [4:0] {
    // ALU register and immediate ops
    OP_ADD,
    OP_SUB,
    OP_SLL,
    OP_SLT,
    OP_SLTU,
    OP_XOR,
    OP_SRL,
    OP_SRA,
    OP_OR,
    OP_AND,
    // Conditional branches
    OP_BEQ,
    OP_BNE,
    OP_BLT,
    OP_BGE,
    OP_BLTU,
    OP_BGEU,
    // Jumps and upper immediates
    OP_JAL,
    OP_JALR,
    OP_LUI,
    OP_AUIPC,
    // Word memory access
    OP_LW,
    OP_SW
  } op_t;

  // One decoded instruction as handed to issue
  typedef struct packed {
    logic [31:0] pc;
    fu_t         fu;
    op_t         op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic        use_imm;
    logic        is_compressed;
    logic        illegal;
  } issue_entry_t;

endpackage

/* hdl/decode_top.sv */
// --------------------
// Decode top level with plain fetch and issue ports.
// Splits the registered issue entry into separate outputs.
// --------------------
`timescale 1ns/1ps

module decode_top
  import decode_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  // Fetch side
  input  logic [31:0] fetch_instr_i,
  input  logic [31:0] fetch_addr_i,
  input  logic        fetch_valid_i,
  output logic        fetch_ready_o,
  // Issue side
  input  logic        issue_ack_i,
  output logic        issue_valid_o,
  output logic [31:0] issue_pc_o,
  output fu_t         issue_fu_o,
  output op_t         issue_op_o,
  output logic [4:0]  issue_rs1_o,
  output logic [4:0]  issue_rs2_o,
  output logic [4:0]  issue_rd_o,
  output logic [31:0] issue_imm_o,
  output logic        issue_use_imm_o,
  output logic        issue_compressed_o,
  output logic        issue_illegal_o,
  output logic        issue_ctrl_flow_o,
  output logic [31:0] issue_orig_instr_o
);

  issue_entry_t issue_entry;

  fetch_if fetch_bus ();

  // Fetch ports drive the bus, ready comes back from decode
  assign fetch_bus.instr = fetch_instr_i;
  assign fetch_bus.addr  = fetch_addr_i;
  assign fetch_bus.valid = fetch_valid_i;
  assign fetch_ready_o   = fetch_bus.ready;

  id_stage id_stage_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .fetch              (fetch_bus.decode),
    .issue_entry_o      (issue_entry),
    .issue_valid_o      (issue_valid_o),
    .issue_ctrl_flow_o  (issue_ctrl_flow_o),
    .issue_orig_instr_o (issue_orig_instr_o),
    .issue_ack_i        (issue_ack_i)
  );

  // Entry fields out to plain ports
  assign issue_pc_o         = issue_entry.pc;
  assign issue_fu_o         = issue_entry.fu;
  assign issue_op_o         = issue_entry.op;
  assign issue_rs1_o        = issue_entry.rs1;
  assign issue_rs2_o        = issue_entry.rs2;
  assign issue_rd_o         = issue_entry.rd;
  assign issue_imm_o        = issue_entry.imm;
  assign issue_use_imm_o    = issue_entry.use_imm;
  assign issue_compressed_o = issue_entry.is_compressed;
  assign issue_illegal_o    = issue_entry.illegal;

endmodule

/* hdl/fetch_if.sv */
// --------------------
// Fetch to decode handshake, one word per valid/ready transfer
// --------------------
`timescale 1ns/1ps

interface fetch_if;

  // Raw word, low half holds a compressed instruction
  logic [31:0] instr;
  // Address of the word
  logic [31:0] addr;
  logic        valid;
  logic        ready;

  // Fetch side offers the word and waits for ready
  modport fetch (
    output instr, addr, valid,
    input  ready
  );

  // Decode side takes the word when it has room
  modport decode (
    input  instr, addr, valid,
    output ready
  );

endinterface

/* hdl/id_stage.sv */
// --------------------
// Decode stage with the ID-to-issue pipeline register.
// Takes one fetch word, holds one entry until issue acknowledges it.
// --------------------
`timescale 1ns/1ps

module id_stage
  import decode_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  fetch_if.decode      fetch,
  output issue_entry_t issue_entry_o,
  output logic         issue_valid_o,
  output logic         issue_ctrl_flow_o,
  output logic [31:0]  issue_orig_instr_o,
  input  logic         issue_ack_i
);

  // Expander outputs
  logic [31:0]  exp_instr;
  logic         is_compressed;
  logic         is_illegal;
  // Decoder outputs
  issue_entry_t dec_entry;
  logic         dec_ctrl_flow;
  logic [31:0]  orig_instr;
  // Pipeline register
  logic         valid_q;
  issue_entry_t entry_q;
  logic [31:0]  orig_instr_q;
  logic         ctrl_flow_q;
  logic         capture;

  compressed_expander compressed_expander_inst (
    .instr_i         (fetch.instr),
    .instr_o         (exp_instr),
    .is_compressed_o (is_compressed),
    .illegal_o       (is_illegal)
  );

  instr_decoder instr_decoder_inst (
    .instr_i         (exp_instr),
    .pc_i            (fetch.addr),
    .is_compressed_i (is_compressed),
    .is_illegal_i    (is_illegal),
    .entry_o         (dec_entry),
    .ctrl_flow_o     (dec_ctrl_flow)
  );

  // Fetched word as seen by issue, upper half dropped for RVC
  assign orig_instr = is_compressed ? {16'b0, fetch.instr[15:0]} : fetch.instr;

  // Room when empty or when the held entry leaves this cycle
  assign capture     = fetch.valid & (~valid_q | issue_ack_i);
  assign fetch.ready = capture;

  // --------------------
  // Pipeline register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q      <= 1'b0;
      entry_q      <= '0;
      orig_instr_q <= '0;
      ctrl_flow_q  <= 1'b0;
    end else begin
      if (capture) begin
        entry_q      <= dec_entry;
        orig_instr_q <= orig_instr;
        ctrl_flow_q  <= dec_ctrl_flow;
      end
      // Flush wins over both ack and a new capture
      if (flush_i) begin
        valid_q <= 1'b0;
      end else if (capture) begin
        valid_q <= 1'b1;
      end else if (issue_ack_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  assign issue_entry_o      = entry_q;
  assign issue_valid_o      = valid_q;
  assign issue_ctrl_flow_o  = ctrl_flow_q;
  assign issue_orig_instr_o = orig_instr_q;

  // --------------------
  // Assertions
  // --------------------
  // Issue may only take an entry that is there
  ack_only_when_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> valid_q
  );

  // Unacknowledged entry waits unchanged for issue
  held_entry_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (valid_q && !issue_ack_i && !flush_i) |=>
      (valid_q && $stable(entry_q) && $stable(orig_instr_q) && $stable(ctrl_flow_q))
  );

endmodule

/* hdl/instr_decoder.sv */
// --------------------
// Combinational RV32I decoder, builds one issue entry per word.
// Illegal entries carry the exception cause in the immediate.
// --------------------
`timescale 1ns/1ps

module instr_decoder
  import decode_pkg::*;
(
  input  logic [31:0]  instr_i,
  input  logic [31:0]  pc_i,
  input  logic         is_compressed_i,
  input  logic         is_illegal_i,
  output issue_entry_t entry_o,
  output logic         ctrl_flow_o
);

  // Instruction fields
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [4:0]  rs1_f;
  logic [4:0]  rs2_f;
  logic [4:0]  rd_f;
  // Sign-extended immediates per format
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  // Decoded values before the illegal override
  fu_t         fu;
  op_t         op;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [31:0] imm;
  logic        use_imm;
  logic        dec_illegal;
  logic        illegal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1_f  = instr_i[19:15];
  assign rs2_f  = instr_i[24:20];
  assign rd_f   = instr_i[11:7];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    // Unused register slots read as x0
    fu          = FU_NONE;
    op          = OP_ADD;
    rs1         = '0;
    rs2         = '0;
    rd          = '0;
    imm         = '0;
    use_imm     = 1'b0;
    dec_illegal = 1'b0;

    case (opcode)
      OPCODE_OP: begin
        fu  = FU_ALU;
        rs1 = rs1_f;
        rs2 = rs2_f;
        rd  = rd_f;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: op = OP_ADD;
          {7'b0100000, 3'b000}: op = OP_SUB;
          {7'b0000000, 3'b001}: op = OP_SLL;
          {7'b0000000, 3'b010}: op = OP_SLT;
          {7'b0000000, 3'b011}: op = OP_SLTU;
          {7'b0000000, 3'b100}: op = OP_XOR;
          {7'b0000000, 3'b101}: op = OP_SRL;
          {7'b0100000, 3'b101}: op = OP_SRA;
          {7'b0000000, 3'b110}: op = OP_OR;
          {7'b0000000, 3'b111}: op = OP_AND;
          default:              dec_illegal = 1'b1;
        endcase
      end
      OPCODE_OP_IMM: begin
        fu      = FU_ALU;
        rs1     = rs1_f;
        rd      = rd_f;
        imm     = imm_i;
        use_imm = 1'b1;
        case (funct3)
          3'b000: op = OP_ADD;
          3'b010: op = OP_SLT;
          3'b011: op = OP_SLTU;
          3'b100: op = OP_XOR;
          3'b110: op = OP_OR;
          3'b111: op = OP_AND;
          // Shifts carry only the shift amount
          3'b001: begin
            op          = OP_SLL;
            imm         = {27'b0, instr_i[24:20]};
            dec_illegal = (funct7 != 7'b0000000);
          end
          default: begin
            op          = (funct7 == 7'b0100000) ? OP_SRA : OP_SRL;
            imm         = {27'b0, instr_i[24:20]};
            dec_illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        fu      = FU_ALU;
        op      = (opcode == OPCODE_LUI) ? OP_LUI : OP_AUIPC;
        rd      = rd_f;
        imm     = imm_u;
        use_imm = 1'b1;
      end
      OPCODE_JAL: begin
        fu      = FU_BRANCH;
        op      = OP_JAL;
        rd      = rd_f;
        imm     = imm_j;
        use_imm = 1'b1;
      end
      OPCODE_JALR: begin
        fu          = FU_BRANCH;
        op          = OP_JALR;
        rs1         = rs1_f;
        rd          = rd_f;
        imm         = imm_i;
        use_imm     = 1'b1;
        dec_illegal = (funct3 != 3'b000);
      end
      OPCODE_BRANCH: begin
        // Offset travels in imm but operands are both registers
        fu  = FU_BRANCH;
        rs1 = rs1_f;
        rs2 = rs2_f;
        imm = imm_b;
        case (funct3)
          3'b000:  op = OP_BEQ;
          3'b001:  op = OP_BNE;
          3'b100:  op = OP_BLT;
          3'b101:  op = OP_BGE;
          3'b110:  op = OP_BLTU;
          3'b111:  op = OP_BGEU;
          default: dec_illegal = 1'b1;
        endcase
      end
      OPCODE_LOAD: begin
        // Only word loads exist in this core
        fu          = FU_LOAD;
        op          = OP_LW;
        rs1         = rs1_f;
        rd          = rd_f;
        imm         = imm_i;
        use_imm     = 1'b1;
        dec_illegal = (funct3 != 3'b010);
      end
      OPCODE_STORE: begin
        fu          = FU_STORE;
        op          = OP_SW;
        rs1         = rs1_f;
        rs2         = rs2_f;
        imm         = imm_s;
        use_imm     = 1'b1;
        dec_illegal = (funct3 != 3'b010);
      end
      default: dec_illegal = 1'b1;
    endcase
  end

  assign illegal = is_illegal_i | dec_illegal;

  // Illegal entries go to no unit, write no register and report the cause
  assign entry_o.pc            = pc_i;
  assign entry_o.fu            = illegal ? FU_NONE : fu;
  assign entry_o.op            = illegal ? OP_ADD : op;
  assign entry_o.rs1           = rs1;
  assign entry_o.rs2           = rs2;
  assign entry_o.rd            = illegal ? 5'd0 : rd;
  assign entry_o.imm           = illegal ? ILLEGAL_CAUSE : imm;
  assign entry_o.use_imm       = illegal ? 1'b0 : use_imm;
  assign entry_o.is_compressed = is_compressed_i;
  assign entry_o.illegal       = illegal;

  assign ctrl_flow_o = ~illegal & (fu == FU_BRANCH);

endmodule

/* verification/tb_decode_top.sv */
// --------------------
// Self-checking testbench for the decode top level.
// Random fetch words are decoded by a reference model and scored at issue.
// --------------------
`timescale 1ns/1ps

module tb_decode_top
  import decode_pkg::*;
();

  localparam int ITEMS_TOTAL = 8 + 4 * 200;
  localparam int CYCLE_LIMIT = ITEMS_TOTAL * 12 + 20 + 100;

  // Expected issue outputs for one accepted fetch word
  typedef struct packed {
    issue_entry_t e;
    logic         ctrl;
    logic [31:0]  orig;
  } exp_t;

  logic clk_i, rst_ni, flush_i, fetch_valid_i, fetch_ready_o, issue_ack_i;
  logic [31:0] fetch_instr_i, fetch_addr_i, issue_pc_o, issue_imm_o, issue_orig_instr_o;
  fu_t         issue_fu_o;
  op_t         issue_op_o;
  logic [4:0]  issue_rs1_o, issue_rs2_o, issue_rd_o;
  logic        issue_valid_o, issue_use_imm_o, issue_compressed_o;
  logic        issue_illegal_o, issue_ctrl_flow_o;
  // 32-bit equivalent of the compressed word on offer
  logic [31:0] item_eq;

  exp_t exp_q[$];
  int err_count = 0;
  int check_count = 0;
  int tests_ok = 0;
  int cycles = 0;

  decode_top decode_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------
  // Encoders and reference model
  // --------------------
  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPCODE_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, OPCODE_JAL};
  endfunction

  function automatic exp_t decode_model(logic [31:0] w, logic [31:0] pc, logic comp,
                                        logic [31:0] raw);
    exp_t x;
    logic ill;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [31:0] imm_i;
    x = '0;
    ill = 1'b0;
    f3 = w[14:12];
    f7 = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    x.e.pc = pc;
    x.e.is_compressed = comp;
    x.orig = comp ? {16'b0, raw[15:0]} : raw;
    x.e.fu = FU_NONE;
    x.e.op = OP_ADD;
    case (w[6:0])
      OPCODE_OP: begin
        x.e.fu = FU_ALU;
        x.e.rs1 = w[19:15];
        x.e.rs2 = w[24:20];
        x.e.rd = w[11:7];
        case ({f7, f3})
          10'h000: x.e.op = OP_ADD;
          10'h100: x.e.op = OP_SUB;
          10'h001: x.e.op = OP_SLL;
          10'h002: x.e.op = OP_SLT;
          10'h003: x.e.op = OP_SLTU;
          10'h004: x.e.op = OP_XOR;
          10'h005: x.e.op = OP_SRL;
          10'h105: x.e.op = OP_SRA;
          10'h006: x.e.op = OP_OR;
          10'h007: x.e.op = OP_AND;
          default: ill = 1'b1;
        endcase
      end
      OPCODE_OP_IMM: begin
        x.e.fu = FU_ALU;
        x.e.rs1 = w[19:15];
        x.e.rd = w[11:7];
        x.e.imm = imm_i;
        x.e.use_imm = 1'b1;
        case (f3)
          3'd0: x.e.op = OP_ADD;
          3'd2: x.e.op = OP_SLT;
          3'd3: x.e.op = OP_SLTU;
          3'd4: x.e.op = OP_XOR;
          3'd6: x.e.op = OP_OR;
          3'd7: x.e.op = OP_AND;
          default: begin
            // Shifts keep only shamt
            x.e.imm = {27'b0, w[24:20]};
            x.e.op = (f3 == 3'd1) ? OP_SLL : (f7[5] ? OP_SRA : OP_SRL);
            ill = (f3 == 3'd1) ? (f7 != 7'd0) : (f7 != 7'd0 && f7 != 7'h20);
          end
        endcase
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        x.e.fu = FU_ALU;
        x.e.op = (w[6:0] == OPCODE_LUI) ? OP_LUI : OP_AUIPC;
        x.e.rd = w[11:7];
        x.e.imm = {w[31:12], 12'b0};
        x.e.use_imm = 1'b1;
      end
      OPCODE_JAL: begin
        x.e.fu = FU_BRANCH;
        x.e.op = OP_JAL;
        x.e.rd = w[11:7];
        x.e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        x.e.use_imm = 1'b1;
      end
      OPCODE_JALR: begin
        x.e.fu = FU_BRANCH;
        x.e.op = OP_JALR;
        x.e.rs1 = w[19:15];
        x.e.rd = w[11:7];
        x.e.imm = imm_i;
        x.e.use_imm = 1'b1;
        ill = (f3 != 3'd0);
      end
      OPCODE_BRANCH: begin
        x.e.fu = FU_BRANCH;
        x.e.rs1 = w[19:15];
        x.e.rs2 = w[24:20];
        x.e.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        case (f3)
          3'd0: x.e.op = OP_BEQ;
          3'd1: x.e.op = OP_BNE;
          3'd4: x.e.op = OP_BLT;
          3'd5: x.e.op = OP_BGE;
          3'd6: x.e.op = OP_BLTU;
          3'd7: x.e.op = OP_BGEU;
          default: ill = 1'b1;
        endcase
      end
      OPCODE_LOAD: begin
        x.e.fu = FU_LOAD;
        x.e.op = OP_LW;
        x.e.rs1 = w[19:15];
        x.e.rd = w[11:7];
        x.e.imm = imm_i;
        x.e.use_imm = 1'b1;
        ill = (f3 != 3'd2);
      end
      OPCODE_STORE: begin
        x.e.fu = FU_STORE;
        x.e.op = OP_SW;
        x.e.rs1 = w[19:15];
        x.e.rs2 = w[24:20];
        x.e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        x.e.use_imm = 1'b1;
        ill = (f3 != 3'd2);
      end
      default: ill = 1'b1;
    endcase
    // Illegal entries go nowhere and carry cause 2
    if (ill) begin
      x.e.fu = FU_NONE;
      x.e.op = OP_ADD;
      x.e.rd = 5'd0;
      x.e.imm = 32'd2;
      x.e.use_imm = 1'b0;
    end
    x.e.illegal = ill;
    x.ctrl = !ill && (x.e.fu == FU_BRANCH);
    return x;
  endfunction

  // --------------------
  // Stimulus generators
  // --------------------
  task automatic gen_legal32(output logic [31:0] w);
    logic [31:0] r;
    logic [2:0] f3;
    int cls;
    r = $urandom;
    cls = $urandom % 9;
    w = r;
    f3 = r[14:12];
    case (cls)
      0: begin
        w[6:0] = OPCODE_OP;
        w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00;
      end
      1: begin
        w[6:0] = OPCODE_OP_IMM;
        if (f3 == 3'd1) w[31:25] = 7'h00;
        else if (f3 == 3'd5) w[31:25] = r[30] ? 7'h20 : 7'h00;
      end
      2: w[6:0] = OPCODE_LUI;
      3: w[6:0] = OPCODE_AUIPC;
      4: w[6:0] = OPCODE_JAL;
      5: begin
        w[6:0] = OPCODE_JALR;
        w[14:12] = 3'd0;
      end
      6: begin
        w[6:0] = OPCODE_BRANCH;
        if (f3 == 3'd2 || f3 == 3'd3) w[14:12] = {1'b1, f3[1:0]};
      end
      7: begin
        w[6:0] = OPCODE_LOAD;
        w[14:12] = 3'd2;
      end
      default: begin
        w[6:0] = OPCODE_STORE;
        w[14:12] = 3'd2;
      end
    endcase
  endtask

  // Supported RVC word and its 32-bit equivalent
  task automatic gen_comp(output logic [15:0] c, output logic [31:0] eq);
    logic [4:0] rd, rs2;
    logic [5:0] i6;
    logic [6:0] u;
    logic [2:0] p1, p2;
    logic [11:0] jo;
    logic [8:0] bo;
    logic [31:0] r;
    r = $urandom;
    rd = r[4:0];
    rs2 = r[9:5];
    i6 = r[15:10];
    u = {r[20:16], 2'b00};
    p1 = r[23:21];
    p2 = r[26:24];
    jo = {r[31:21], 1'b0};
    bo = {r[31:24], 1'b0};
    case ($urandom % 10)
      0: begin
        c = {3'b000, i6[5], rd, i6[4:0], 2'b01};
        eq = {{6{i6[5]}}, i6, rd, 3'b000, rd, OPCODE_OP_IMM};
      end
      1: begin
        c = {3'b010, i6[5], rd, i6[4:0], 2'b01};
        eq = {{6{i6[5]}}, i6, 5'd0, 3'b000, rd, OPCODE_OP_IMM};
      end
      2: begin
        if (rd == 5'd0 || rd == 5'd2) rd = 5'd3;
        if (i6 == 6'd0) i6 = 6'd1;
        c = {3'b011, i6[5], rd, i6[4:0], 2'b01};
        eq = {{14{i6[5]}}, i6, rd, OPCODE_LUI};
      end
      3, 4: begin
        if (rs2 == 5'd0) rs2 = 5'd1;
        c = {3'b100, r[0], rd, rs2, 2'b10};
        eq = {7'd0, rs2, (r[0] ? rd : 5'd0), 3'b000, rd, OPCODE_OP};
      end
      5: begin
        c = {3'b010, u[5:3], p1, u[2], u[6], p2, 2'b00};
        eq = {5'd0, u, 2'b01, p1, 3'b010, 2'b01, p2, OPCODE_LOAD};
      end
      6: begin
        c = {3'b110, u[5:3], p1, u[2], u[6], p2, 2'b00};
        eq = enc_s({5'd0, u}, {2'b01, p2}, {2'b01, p1});
      end
      7: begin
        c = {3'b101, jo[11], jo[4], jo[9:8], jo[10], jo[6], jo[7], jo[3:1], jo[5], 2'b01};
        eq = enc_j({{9{jo[11]}}, jo});
      end
      default: begin
        c = {2'b11, r[0], bo[8], bo[4:3], p1, bo[7:6], bo[2:1], bo[5], 2'b01};
        eq = enc_b({{4{bo[8]}}, bo}, {2'b01, p1}, {2'b00, r[0]});
      end
    endcase
  endtask

  // Unsupported RVC words or 32-bit words with an unknown opcode
  task automatic gen_illegal(output logic [31:0] w);
    logic [31:0] r;
    r = $urandom;
    w = r;
    case ($urandom % 5)
      0: w[15:0] = 16'h0000;
      1: w[15:0] = {3'b000, r[10:0], 2'b10};
      2: w[15:0] = {3'b001, r[10:0], 2'b01};
      3: w[15:0] = {3'b011, r[5], 5'd2, r[4:0], 2'b01};
      default: begin
        w[1:0] = 2'b11;
        while (w[6:0] inside {OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC,
                              OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH, OPCODE_LOAD,
                              OPCODE_STORE}) begin
          w[6:2] = 5'($urandom);
        end
      end
    endcase
  endtask

  // Put the next word on the fetch ports
  // Kind 3 mixes all classes
  task automatic present_item(input int kind);
    logic [31:0] w, eq, r;
    logic [15:0] c;
    int sel;
    sel = (kind == 3) ? int'($urandom % 3) : kind;
    r = $urandom;
    eq = 32'd0;
    if (sel == 0) begin
      gen_legal32(w);
    end else if (sel == 1) begin
      gen_comp(c, eq);
      w = {r[15:0], c};
    end else begin
      gen_illegal(w);
    end
    fetch_instr_i <= w;
    fetch_addr_i <= {r[31:1], 1'b0};
    fetch_valid_i <= 1'b1;
    item_eq <= eq;
  endtask

  // --------------------
  // Scoreboard
  // --------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic compare_entry(input exp_t x);
    check_val("issue_pc_o", issue_pc_o, x.e.pc);
    check_val("issue_fu_o", 32'(issue_fu_o), 32'(x.e.fu));
    check_val("issue_op_o", 32'(issue_op_o), 32'(x.e.op));
    check_val("issue_rs1_o", 32'(issue_rs1_o), 32'(x.e.rs1));
    check_val("issue_rs2_o", 32'(issue_rs2_o), 32'(x.e.rs2));
    check_val("issue_rd_o", 32'(issue_rd_o), 32'(x.e.rd));
    check_val("issue_imm_o", issue_imm_o, x.e.imm);
    check_val("issue_use_imm_o", 32'(issue_use_imm_o), 32'(x.e.use_imm));
    check_val("issue_compressed_o", 32'(issue_compressed_o), 32'(x.e.is_compressed));
    check_val("issue_illegal_o", 32'(issue_illegal_o), 32'(x.e.illegal));
    check_val("issue_ctrl_flow_o", 32'(issue_ctrl_flow_o), 32'(x.ctrl));
    check_val("issue_orig_instr_o", issue_orig_instr_o, x.orig);
  endtask

  // Every edge is checked so held entries and ready are watched too
  always @(posedge clk_i) begin : scoreboard
    logic comp;
    if (rst_ni) begin
      comp = (fetch_instr_i[1:0] != 2'b11);
      check_val("issue_valid_o", 32'(issue_valid_o), 32'(exp_q.size() != 0));
      check_val("fetch_ready_o", 32'(fetch_ready_o),
                32'(fetch_valid_i && (exp_q.size() == 0 || issue_ack_i)));
      if (exp_q.size() != 0) compare_entry(exp_q[0]);
      if (issue_ack_i && exp_q.size() != 0) void'(exp_q.pop_front());
      if (flush_i) begin
        exp_q.delete();
      end else if (fetch_valid_i && fetch_ready_o) begin
        exp_q.push_back(decode_model(comp ? item_eq : fetch_instr_i, fetch_addr_i, comp,
                                     fetch_instr_i));
      end
    end
  end

  // --------------------
  // Test sequencing
  // --------------------
  task automatic run_test(input int id, input string name, input int kind, input int count,
                          input int ack_pct, input int flush_pct);
    int sent;
    int errs0;
    logic xfer, v_next, do_flush;
    errs0 = err_count;
    sent = 0;
    @(posedge clk_i);
    present_item(kind);
    while (sent < count) begin
      @(posedge clk_i);
      xfer = fetch_valid_i && fetch_ready_o;
      // Valid after this edge
      // Ack only goes to an entry that is there
      v_next = flush_i ? 1'b0 : (xfer ? 1'b1 : (issue_ack_i ? 1'b0 : issue_valid_o));
      do_flush = int'($urandom % 100) < flush_pct;
      flush_i <= do_flush;
      issue_ack_i <= !do_flush && v_next && (int'($urandom % 100) < ack_pct);
      if (xfer) begin
        sent++;
        if (sent < count) present_item(kind);
        else fetch_valid_i <= 1'b0;
      end
    end
    // Drain the last entry
    do begin
      @(posedge clk_i);
      v_next = flush_i ? 1'b0 : (issue_ack_i ? 1'b0 : issue_valid_o);
      flush_i <= 1'b0;
      issue_ack_i <= v_next;
    end while (v_next);
    @(posedge clk_i);
    if (err_count == errs0) tests_ok++;
    $display("Test %0d %s: %s", id, name, (err_count == errs0) ? "ok" : "errors");
  endtask

  initial begin
    void'($urandom(13689));
    rst_ni = 1'b0;
    flush_i = 1'b0;
    fetch_instr_i = '0;
    fetch_addr_i = '0;
    fetch_valid_i = 1'b0;
    issue_ack_i = 1'b0;
    item_eq = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    // Every issue output reads zero out of reset
    compare_entry('0);
    run_test(1, "reset and single fetch", 0, 8, 100, 0);
    run_test(2, "random RV32I", 0, 200, 100, 0);
    run_test(3, "compressed and illegal", 3, 200, 100, 0);
    run_test(4, "ack back-pressure", 3, 200, 35, 0);
    run_test(5, "random flush", 3, 200, 60, 10);
    $display("Tests passed %0d of 5, checks %0d, errors %0d", tests_ok, check_count, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
hdl/decode_pkg.sv
hdl/fetch_if.sv
hdl/compressed_expander.sv
hdl/instr_decoder.sv
hdl/id_stage.sv
hdl/decode_top.sv
verification/tb_decode_top.sv
